// ==== hw/board_pkg.sv ====
// shared address map, register indices, watchdog and blink constants for the board control block
package board_pkg;

    // ---------------------------------------------------------
    // bus and watchdog types
    // ---------------------------------------------------------
    typedef logic [15:0] reg_addr_t;        // host register address
    typedef logic [31:0] reg_data_t;        // host register data word
    typedef logic [15:0] wdog_period_t;     // period in ticks of 256 clocks
    typedef logic [23:0] wdog_count_t;      // raw watchdog counter

    // period phase shown on the board LED
    typedef enum logic [2:0] {
        wdog_disable     = 3'd0,            // period of zero, watchdog off
        wdog_phase_one   = 3'd1,
        wdog_phase_two   = 3'd2,
        wdog_phase_three = 3'd3,
        wdog_phase_four  = 3'd4,
        wdog_phase_five  = 3'd5             // anything above limit four
    } wdog_phase_t;

    // ---------------------------------------------------------
    // address map
    // ---------------------------------------------------------
    localparam logic [3:0] addr_main    = 4'd0;    // address bits 15..12 of the main space

    // main register indices on address bits 3..0
    localparam logic [3:0] reg_status   = 4'd0;    // reboot request bits 21..20
    localparam logic [3:0] reg_phyctrl  = 4'd1;
    localparam logic [3:0] reg_phydata  = 4'd2;
    localparam logic [3:0] reg_timeout  = 4'd3;    // led mode bit 31, period 15..0
    localparam logic [3:0] reg_fversion = 4'd4;

    localparam reg_data_t fw_version = 32'h0000_0007;  // firmware release returned on reads

    // ---------------------------------------------------------
    // watchdog
    // ---------------------------------------------------------
    localparam wdog_period_t wdog_period_default = 16'h1680;  // about 30 ms at 49 MHz
    localparam int unsigned  wdog_tick_shift     = 8;         // counter bits below the period

    // upper bounds of phases one to four, inclusive
    localparam wdog_period_t wdog_limit_one   = 16'h2580;
    localparam wdog_period_t wdog_limit_two   = 16'h4B00;
    localparam wdog_period_t wdog_limit_three = 16'h7080;
    localparam wdog_period_t wdog_limit_four  = 16'h9600;

    // LED pulse train, in clock cycles
    localparam logic [7:0] blink_on  = 8'd4;
    localparam logic [7:0] blink_off = 8'd4;
    localparam logic [7:0] blink_gap = 8'd16;

endpackage

// ==== hw/board_regs.sv ====
// main board register file, stores host settings and serves readback with external board fallback
module board_regs
    import board_pkg::*;
(
    input  logic         sysclk,
    input  logic         rst_n,           // synchronous, active low

    // host read port
    input  reg_addr_t    reg_raddr,       // only bits 3..0 are decoded
    output reg_data_t    reg_rdata,       // same-cycle read data
    input  reg_data_t    reg_rdata_ext,   // data from the external board

    // host write port, one-cycle strobe
    input  reg_addr_t    reg_waddr,
    input  reg_data_t    reg_wdata,
    input  logic         reg_wen,

    // settings for the rest of the block
    output logic         reboot,          // FPGA reboot request
    output wdog_period_t wdog_period,     // watchdog period in 256-clock ticks
    output logic         wdog_led_sel     // 1 = LED blinks the period phase
);

    // ---------------------------------------------------------
    // storage
    // ---------------------------------------------------------

    // PHY words are only kept here for readback
    // the PHY logic that acts on them lives elsewhere
    logic [15:0] phy_ctrl;               // last PHY request word
    logic [15:0] phy_data;               // last PHY register transfer word

    logic        write_main;             // strobe hits the main space

    // ---------------------------------------------------------
    // write decode
    // ---------------------------------------------------------

    // main space needs the top nibble match and a clear second nibble
    assign write_main = (reg_waddr[15:12] == addr_main) &&
                        (reg_waddr[7:4] == 4'd0) &&
                        reg_wen;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            reboot       <= 1'b0;
            wdog_led_sel <= 1'b0;                  // LED starts as timeout mirror
            wdog_period  <= wdog_period_default;
            phy_ctrl     <= 16'd0;
            phy_data     <= 16'd0;
        end else if (write_main) begin
            case (reg_waddr[3:0])
                reg_status: begin
                    // bit 21 arms the request, bit 20 carries it
                    reboot <= reg_wdata[21] ? reg_wdata[20] : 1'b0;
                end
                reg_phyctrl: begin
                    phy_ctrl <= reg_wdata[15:0];
                end
                reg_phydata: begin
                    phy_data <= reg_wdata[15:0];
                end
                reg_timeout: begin
                    wdog_led_sel <= reg_wdata[31];     // LED mode
                    wdog_period  <= reg_wdata[15:0];   // zero stops the watchdog
                end
                default: begin
                    // fversion is read-only, other indices belong to other blocks
                end
            endcase
        end
    end

    // ---------------------------------------------------------
    // read multiplexer
    // ---------------------------------------------------------

    // unclaimed indices fall through to the external board
    always_comb begin
        case (reg_raddr[3:0])
            reg_phyctrl:  reg_rdata = {16'd0, phy_ctrl};
            reg_phydata:  reg_rdata = {16'd0, phy_data};
            reg_timeout:  reg_rdata = {wdog_led_sel, 15'd0, wdog_period};
            reg_fversion: reg_rdata = fw_version;
            default:      reg_rdata = reg_rdata_ext;   // status and the rest
        endcase
    end

endmodule

// ==== hw/wdog_timer.sv ====
// watchdog that counts clocks since the last host write and raises a sticky timeout flag
module wdog_timer
    import board_pkg::*;
(
    input  logic         sysclk,
    input  logic         rst_n,          // synchronous, active low
    input  logic         reg_wen,        // any host write restarts the count
    input  logic         wdog_clear,     // clears the flag, e.g. on power-up
    input  wdog_period_t wdog_period,    // zero disables the watchdog
    output logic         wdog_timeout    // sticky timeout flag
);

    // ---------------------------------------------------------
    // counter
    // ---------------------------------------------------------

    // 24-bit count, upper 16 bits compared to the period
    // so one period tick is 256 clocks
    wdog_count_t wdog_count;
    logic        period_hit;             // scaled count reached the period
    logic        wdog_run;               // watchdog enabled

    assign wdog_run   = (wdog_period != '0);
    assign period_hit = (wdog_count[wdog_tick_shift +: 16] == wdog_period);

    // clear beats write, write beats counting
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (wdog_clear) begin
            wdog_count   <= '0;                  // restart from zero
            wdog_timeout <= 1'b0;                // drop the flag
        end else if (reg_wen) begin
            wdog_count   <= '0;                  // host is alive
        end else if (wdog_run) begin
            if (period_hit) begin
                wdog_timeout <= 1'b1;            // count holds here until a write
            end else begin
                wdog_count <= wdog_count + 24'd1;
            end
        end
    end

endmodule

// ==== hw/wdog_led.sv ====
// period phase encoder and board LED driver, blinks the phase number or mirrors the timeout
module wdog_led
    import board_pkg::*;
(
    input  logic         sysclk,
    input  logic         rst_n,                // synchronous, active low
    input  wdog_period_t wdog_period,
    input  logic         wdog_led_sel,         // 1 = blink phase, 0 = show timeout
    input  logic         wdog_timeout,
    output wdog_phase_t  wdog_period_status,   // registered phase code
    output logic         wdog_led_out
);

    typedef enum logic [1:0] {
        pulse_high,                            // LED on for blink_on cycles
        pulse_low,                             // LED off between pulses
        gap                                    // long dark stretch ending a frame
    } blink_state_t;

    blink_state_t state;
    logic [7:0]   cycle_cnt;                   // cycles spent in the current state
    logic [2:0]   pulse_cnt;                   // pulse number within the frame
    logic         timeout_q;                   // one-stage copy of the flag

    // ---------------------------------------------------------
    // phase encoder
    // ---------------------------------------------------------
    function automatic wdog_phase_t phase_of(input wdog_period_t p);
        if (p == '0)                    return wdog_disable;
        else if (p <= wdog_limit_one)   return wdog_phase_one;
        else if (p <= wdog_limit_two)   return wdog_phase_two;
        else if (p <= wdog_limit_three) return wdog_phase_three;
        else if (p <= wdog_limit_four)  return wdog_phase_four;
        else                            return wdog_phase_five;
    endfunction

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_period_status <= wdog_phase_one;   // matches the default period
            timeout_q          <= 1'b0;
        end else begin
            wdog_period_status <= phase_of(wdog_period);
            timeout_q          <= wdog_timeout;
        end
    end

    // ---------------------------------------------------------
    // blink FSM
    // ---------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n || !wdog_led_sel || wdog_period_status == wdog_disable) begin
            state     <= gap;                       // idle dark, frame restarts clean
            cycle_cnt <= 8'd0;
            pulse_cnt <= 3'd0;
        end else begin
            case (state)
                gap: begin
                    if (cycle_cnt == blink_gap - 8'd1) begin
                        state     <= pulse_high;    // start a new frame
                        cycle_cnt <= 8'd0;
                        pulse_cnt <= 3'd1;
                    end else begin
                        cycle_cnt <= cycle_cnt + 8'd1;
                    end
                end
                pulse_high: begin
                    if (cycle_cnt == blink_on - 8'd1) begin
                        state     <= pulse_low;
                        cycle_cnt <= 8'd0;
                    end else begin
                        cycle_cnt <= cycle_cnt + 8'd1;
                    end
                end
                pulse_low: begin
                    if (cycle_cnt == blink_off - 8'd1) begin
                        cycle_cnt <= 8'd0;
                        // >= also ends the frame if the phase dropped mid-frame
                        if (pulse_cnt >= wdog_period_status) begin
                            state     <= gap;
                            pulse_cnt <= 3'd0;
                        end else begin
                            state     <= pulse_high;
                            pulse_cnt <= pulse_cnt + 3'd1;
                        end
                    end else begin
                        cycle_cnt <= cycle_cnt + 8'd1;
                    end
                end
                default: begin
                    state     <= gap;
                    cycle_cnt <= 8'd0;
                end
            endcase
        end
    end

    // LED only lit in pulse_high when blinking
    assign wdog_led_out = wdog_led_sel ? (state == pulse_high) : timeout_q;

endmodule

// ==== hw/board_ctrl_top.sv ====
// top level of the board control block, joins register file, watchdog timer and LED driver
module board_ctrl_top
    import board_pkg::*;
(
    input  logic         sysclk,
    input  logic         rst_n,                // synchronous, active low

    // host register bus
    input  reg_addr_t    reg_raddr,
    input  reg_addr_t    reg_waddr,
    input  reg_data_t    reg_wdata,
    input  logic         reg_wen,              // one-cycle write strobe
    input  reg_data_t    reg_rdata_ext,        // external board read data
    output reg_data_t    reg_rdata,

    // board control
    input  logic         wdog_clear,
    output logic         reboot,
    output logic         wdog_timeout,
    output wdog_phase_t  wdog_period_status,
    output logic         wdog_led_out
);

    // ---------------------------------------------------------
    // settings from the register file
    // ---------------------------------------------------------
    wdog_period_t wdog_period;                 // to timer and LED driver
    logic         wdog_led_sel;                // LED mode bit

    board_regs regs_i (
        .sysclk        (sysclk),
        .rst_n         (rst_n),
        .reg_raddr     (reg_raddr),
        .reg_rdata     (reg_rdata),
        .reg_rdata_ext (reg_rdata_ext),
        .reg_waddr     (reg_waddr),
        .reg_wdata     (reg_wdata),
        .reg_wen       (reg_wen),
        .reboot        (reboot),
        .wdog_period   (wdog_period),
        .wdog_led_sel  (wdog_led_sel)
    );

    // raw strobe, so writes to any space keep the watchdog quiet
    wdog_timer timer_i (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .reg_wen      (reg_wen),
        .wdog_clear   (wdog_clear),
        .wdog_period  (wdog_period),
        .wdog_timeout (wdog_timeout)
    );

    wdog_led led_i (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .wdog_period        (wdog_period),
        .wdog_led_sel       (wdog_led_sel),
        .wdog_timeout       (wdog_timeout),
        .wdog_period_status (wdog_period_status),
        .wdog_led_out       (wdog_led_out)
    );

endmodule

// ==== sim/board_ctrl_properties.sv ====
// concurrent checks on the watchdog flag and the reboot request, bound into the RTL modules
module board_ctrl_properties (
    input logic sysclk,
    input logic rst_n,
    input logic wdog_clear,
    input logic wdog_timeout,
    input logic reboot
);
    timeunit 1ns;
    timeprecision 100ps;

    // sticky flag, only a clear or a reset may drop it
    flag_sticky: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        $fell(wdog_timeout) |-> ($past(wdog_clear) || !$past(rst_n))
    ) else $error("watchdog flag fell without a clear");

    flag_cleared: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        wdog_clear |=> !wdog_timeout                    // clear wins over counting
    ) else $error("watchdog flag still high after a clear");

    reboot_reset: assert property (
        @(posedge sysclk) !rst_n |=> !reboot
    ) else $error("reboot request high after reset");

endmodule

// the timer has no reboot and the register file has no flag, those inputs are tied low
bind wdog_timer board_ctrl_properties timer_props_i (
    .sysclk       (sysclk),
    .rst_n        (rst_n),
    .wdog_clear   (wdog_clear),
    .wdog_timeout (wdog_timeout),
    .reboot       (1'b0)
);

bind board_regs board_ctrl_properties regs_props_i (
    .sysclk       (sysclk),
    .rst_n        (rst_n),
    .wdog_clear   (1'b0),
    .wdog_timeout (1'b0),
    .reboot       (reboot)
);

// ==== sim/board_ctrl_tb.sv ====
// testbench for the board control block, seeded random register traffic against a model
module board_ctrl_tb
    import board_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic         sysclk = 1'b0;
    logic         rst_n;
    reg_addr_t    reg_raddr, reg_waddr;
    reg_data_t    reg_wdata, reg_rdata_ext, reg_rdata;
    logic         reg_wen, wdog_clear;
    logic         reboot, wdog_timeout, wdog_led_out;
    wdog_phase_t  wdog_period_status;

    integer       seed = 32'haf74;
    int           error_count = 0;
    int           pass_count  = 0;
    int           cycle_count = 0;

    // model of the stored settings
    logic [15:0]  m_phy_ctrl, m_phy_data, m_period;
    logic         m_led_sel, m_reboot;

    wdog_period_t blink_periods [5] = '{16'h0100, 16'h3000, 16'h5000, 16'h8000, 16'hC000};

    board_ctrl_top dut_i (.*);

    always #2 sysclk = ~sysclk;                           // 4 ns period

    // run limit, about twice the summed test length
    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 6000) begin
            $display("ERROR: run stopped at cycle %0d, a test never finished", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count++;
        end else begin
            pass_count++;
        end
    endtask

    function automatic reg_data_t rand32();
        return $random(seed);
    endfunction

    function automatic reg_addr_t main_addr(input logic [3:0] idx, input logic [3:0] fill);
        return {addr_main, fill, 4'h0, idx};              // bits 11..8 not decoded
    endfunction

    // outside the main space, by nonzero bits 7..4 or by a nonzero space nibble
    function automatic reg_addr_t foreign_addr(input reg_addr_t r);
        reg_addr_t a;
        a = r;
        if (r[0]) begin
            a[4] = 1'b1;                                   // nonzero bits 7..4, never main
        end else begin
            a[7:4] = 4'h0;
            a[12]  = 1'b1;                                 // space nibble alone keeps it out
        end
        return a;
    endfunction

    function automatic logic [2:0] expected_phase(input logic [15:0] p);
        if (p == 16'd0)              return 3'd0;
        if (p <= wdog_limit_one)     return 3'd1;
        if (p <= wdog_limit_two)     return 3'd2;
        if (p <= wdog_limit_three)   return 3'd3;
        if (p <= wdog_limit_four)    return 3'd4;
        return 3'd5;
    endfunction

    function automatic reg_data_t expected_rdata(input logic [3:0] idx, input reg_data_t ext);
        case (idx)
            reg_phyctrl:  return {16'd0, m_phy_ctrl};
            reg_phydata:  return {16'd0, m_phy_data};
            reg_timeout:  return {m_led_sel, 15'd0, m_period};
            reg_fversion: return fw_version;
            default:      return ext;                      // external board data
        endcase
    endfunction

    // one strobe, then the model follows the main-space rules
    task automatic host_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge sysclk);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        @(posedge sysclk);
        reg_wen   <= 1'b0;
        if (addr[15:12] == addr_main && addr[7:4] == 4'd0) begin
            case (addr[3:0])
                reg_status:  m_reboot = data[21] ? data[20] : 1'b0;
                reg_phyctrl: m_phy_ctrl = data[15:0];
                reg_phydata: m_phy_data = data[15:0];
                reg_timeout: begin
                    m_led_sel = data[31];
                    m_period  = data[15:0];
                end
                default: ;
            endcase
        end
    endtask

    task automatic read_check(input logic [3:0] idx);
        reg_data_t ext;
        reg_data_t rnd;
        ext = rand32();
        rnd = rand32();
        @(posedge sysclk);
        reg_raddr     <= {rnd[15:4], idx};                 // upper bits are noise
        reg_rdata_ext <= ext;
        @(negedge sysclk);
        check_value("reg_rdata", expected_rdata(idx, ext), reg_rdata);
    endtask

    task automatic pulse_clear();
        @(posedge sysclk);
        wdog_clear <= 1'b1;
        @(posedge sysclk);
        wdog_clear <= 1'b0;
        @(negedge sysclk);
    endtask

    task automatic wait_for_timeout(input int limit, output int cycles);
        cycles = 0;
        while (!wdog_timeout && cycles < limit) begin
            @(posedge sysclk);
            cycles++;
            @(negedge sysclk);
        end
    endtask

    // seen goes high if the flag (or the LED) is high on any sampled cycle
    task automatic watch_for_high(input int cycles, input bit use_led, output bit seen);
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge sysclk);
            seen = seen | (use_led ? wdog_led_out : wdog_timeout);
        end
    endtask

    // rising LED edges between two low runs of blink_gap cycles
    task automatic count_blinks(output int pulses);
        int low_run;
        bit armed;
        bit done;
        bit led_prev;
        low_run  = 0;
        armed    = 1'b0;
        done     = 1'b0;
        led_prev = 1'b1;                                   // ignore a pulse already lit
        pulses   = 0;
        for (int n = 0; n < 300 && !done; n++) begin
            @(negedge sysclk);
            if (wdog_led_out) begin
                if (!led_prev && armed)
                    pulses++;
                low_run = 0;
            end else begin
                low_run++;
                if (low_run == int'(blink_gap)) begin
                    done  = armed && pulses > 0;           // second gap closes the frame
                    armed = 1'b1;
                end
            end
            led_prev = wdog_led_out;
        end
        if (!done)
            pulses = -1;                                   // no whole frame seen
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        int           start_errors;
        int           rise_cycles;
        int           pulses;
        bit           seen;
        bit           saw_rise;
        logic         prev;
        reg_addr_t    addr;
        reg_data_t    data;
        reg_data_t    rnd;
        wdog_period_t p;
        wdog_period_t periods [$];

        rst_n         = 1'b0;
        reg_raddr     = '0;
        reg_waddr     = '0;
        reg_wdata     = '0;
        reg_wen       = 1'b0;
        reg_rdata_ext = '0;
        wdog_clear    = 1'b0;
        m_phy_ctrl    = '0;
        m_phy_data    = '0;
        m_period      = wdog_period_default;
        m_led_sel     = 1'b0;
        m_reboot      = 1'b0;
        repeat (4) @(posedge sysclk);
        rst_n <= 1'b1;

        // reset values
        start_errors = error_count;
        @(negedge sysclk);
        check_value("reboot", 32'(m_reboot), 32'(reboot));
        check_value("wdog_timeout", 32'd0, 32'(wdog_timeout));
        check_value("wdog_led_out", 32'd0, 32'(wdog_led_out));
        check_value("wdog_period_status", 32'(expected_phase(m_period)), 32'(wdog_period_status));
        read_check(reg_timeout);
        read_check(reg_phyctrl);
        read_check(reg_phydata);
        report_test("reset", start_errors);

        // register readback with foreign writes mixed in
        start_errors = error_count;
        for (int i = 0; i < 40; i++) begin
            rnd  = rand32();
            data = rand32();
            case (rnd[1:0])
                2'd0:    addr = main_addr(reg_phyctrl, rnd[11:8]);
                2'd1:    addr = main_addr(reg_phydata, rnd[11:8]);
                2'd2:    addr = main_addr(reg_timeout, rnd[11:8]);
                default: addr = foreign_addr(rnd[31:16]);
            endcase
            host_write(addr, data);
            read_check(rnd[7:4]);
        end
        for (int i = 0; i < 16; i++)
            read_check(4'(i));
        report_test("readback", start_errors);

        // reboot enable-bit rule
        start_errors = error_count;
        for (int i = 0; i < 20; i++) begin
            rnd  = rand32();
            host_write(main_addr(reg_status, rnd[11:8]), rand32());
            @(negedge sysclk);
            check_value("reboot", 32'(m_reboot), 32'(reboot));
        end
        report_test("reboot", start_errors);

        // phase codes at and around every threshold
        start_errors = error_count;
        periods = '{16'd0, wdog_limit_one, wdog_limit_two, wdog_limit_three, wdog_limit_four};
        periods.push_back(wdog_limit_one + 16'd1);
        periods.push_back(wdog_limit_two + 16'd1);
        periods.push_back(wdog_limit_three + 16'd1);
        periods.push_back(wdog_limit_four + 16'd1);
        repeat (6) begin
            rnd = rand32();
            periods.push_back(rnd[15:0]);
        end
        foreach (periods[j]) begin
            host_write(main_addr(reg_timeout, 4'h0), {16'd0, periods[j]});
            repeat (2) @(posedge sysclk);
            @(negedge sysclk);
            check_value("wdog_period_status", 32'(expected_phase(m_period)),
                        32'(wdog_period_status));
        end
        report_test("phase", start_errors);

        // watchdog rise, stickiness, clear, keepalive and disable
        start_errors = error_count;
        host_write(main_addr(reg_timeout, 4'h0), 32'd3);
        wait_for_timeout(3 * 256 + 3, rise_cycles);
        check_value("wdog_timeout", 32'd1, 32'(wdog_timeout));
        check_value("wdog_rise_early", 32'd0, 32'(rise_cycles < 3 * 256));
        repeat (3) begin
            rnd = rand32();
            host_write(foreign_addr(rnd[31:16]), rand32());
            @(negedge sysclk);
            check_value("wdog_timeout", 32'd1, 32'(wdog_timeout));  // sticky
        end
        pulse_clear();
        check_value("wdog_timeout", 32'd0, 32'(wdog_timeout));
        repeat (8) begin
            watch_for_high(100, 1'b0, seen);
            check_value("wdog_timeout", 32'd0, 32'(seen));
            rnd = rand32();
            host_write(foreign_addr(rnd[31:16]), rand32());
        end
        host_write(main_addr(reg_timeout, 4'h0), 32'd0);          // stop the count
        watch_for_high(800, 1'b0, seen);
        check_value("wdog_timeout", 32'd0, 32'(seen));
        report_test("watchdog", start_errors);

        // LED mirrors the flag one cycle late
        start_errors = error_count;
        host_write(main_addr(reg_timeout, 4'h0), 32'd1);
        @(negedge sysclk);
        prev     = wdog_timeout;
        saw_rise = 1'b0;
        for (int n = 0; n < 300; n++) begin
            @(posedge sysclk);
            wdog_clear <= (n == 280);                              // drop the flag near the end
            @(negedge sysclk);
            check_value("wdog_led_out", 32'(prev), 32'(wdog_led_out));
            saw_rise = saw_rise | wdog_timeout;
            prev     = wdog_timeout;
        end
        check_value("wdog_timeout_seen", 32'd1, 32'(saw_rise));

        // blink mode, one frame per phase
        for (int i = 0; i < 5; i++) begin
            rnd = rand32();
            p   = blink_periods[i] | {8'd0, rnd[7:0]};
            host_write(main_addr(reg_timeout, 4'h0), {1'b1, 15'd0, p});
            count_blinks(pulses);
            check_value("led_pulses", 32'(expected_phase(m_period)), 32'(pulses));
        end
        host_write(main_addr(reg_timeout, 4'h0), {1'b1, 31'd0});  // disable phase
        repeat (3) @(posedge sysclk);
        watch_for_high(100, 1'b1, seen);
        check_value("wdog_led_out", 32'd0, 32'(seen));
        report_test("led", start_errors);

        $display("checks passed %0d, checks failed %0d", pass_count, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
hw/board_pkg.sv
hw/board_regs.sv
hw/wdog_timer.sv
hw/wdog_led.sv
hw/board_ctrl_top.sv
sim/board_ctrl_properties.sv
sim/board_ctrl_tb.sv
